//--- w3d_bus_pkg.sv
package w3d_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// One single-beat transaction as a host issues it
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              write;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;  // Byte enables for writes
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;  // Zero on writes and on errors
		logic              err;
	} bus_rsp_t;

	// Answer given by a decoding stage that finds no target for the address
	localparam bus_rsp_t RSP_ERR = '{rdata: '0, err: 1'b1};

endpackage

//--- w3d_map_pkg.sv
package w3d_map_pkg;

	// Top three address bits select the region
	localparam logic [2:0] REGION_DRAM = 3'd0;  // 0x0000_0000 up to 0x1fff_ffff
	localparam logic [2:0] REGION_MMIO = 3'd1;  // 0x2000_0000 up to 0x3fff_ffff

	localparam logic UNIT_GFX_CTRL    = 1'b0;  // 0x2000_0000 window
	localparam logic UNIT_EXTERNAL_IO = 1'b1;  // 0x3000_0000 window

	// Highest implemented register offset inside an MMIO unit
	localparam logic [27:0] MMIO_REG_LAST = 28'h0ff_ffff;

	// One address word, read as a DRAM address or as an MMIO register address
	typedef union packed {
		struct packed {
			logic [2:0]  region;
			logic [28:0] offset;
		} dram;
		struct packed {
			logic [2:0]  region;
			logic        unit;
			logic [27:0] reg_addr;  // Bits 27:24 set means a reserved register
		} mmio;
	} map_addr_u;

endpackage

//--- w3d_interconnect_host_data.sv
`timescale 1ns/1ns

module w3d_interconnect_host_data
	import w3d_bus_pkg::*;
	import w3d_map_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	input  logic     host_req_valid,
	output logic     host_req_ready,
	input  bus_req_t host_req,
	output logic     host_rsp_valid,
	input  logic     host_rsp_ready,
	output bus_rsp_t host_rsp,

	output logic     dram_req_valid,
	input  logic     dram_req_ready,
	output bus_req_t dram_req,
	input  logic     dram_rsp_valid,
	output logic     dram_rsp_ready,
	input  bus_rsp_t dram_rsp,

	output logic     mmio_req_valid,
	input  logic     mmio_req_ready,
	output bus_req_t mmio_req,
	input  logic     mmio_rsp_valid,
	output logic     mmio_rsp_ready,
	input  bus_rsp_t mmio_rsp
);

	map_addr_u addr;
	logic      hit_dram;
	logic      hit_mmio;
	logic      accept;
	logic      busy;
	logic      own_dram;
	logic      own_mmio;
	bus_req_t  req_q;

	assign addr     = host_req.addr;
	assign hit_dram = addr.dram.region == REGION_DRAM;
	assign hit_mmio = addr.dram.region == REGION_MMIO;

	assign host_req_ready = !busy;
	assign accept         = host_req_valid && host_req_ready;

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= host_req;
	end

	assign dram_req = req_q;
	assign mmio_req = req_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy           <= 1'b0;
			own_dram       <= 1'b0;
			own_mmio       <= 1'b0;
			dram_req_valid <= 1'b0;
			mmio_req_valid <= 1'b0;
		end else if (accept) begin
			busy           <= 1'b1;
			own_dram       <= hit_dram;  // Neither owner set means an unmapped access
			own_mmio       <= hit_mmio;
			dram_req_valid <= hit_dram;
			mmio_req_valid <= hit_mmio;
		end else begin
			if (dram_req_ready)
				dram_req_valid <= 1'b0;
			if (mmio_req_ready)
				mmio_req_valid <= 1'b0;
			if (host_rsp_valid && host_rsp_ready)
				busy <= 1'b0;
		end
	end

	// Only the owning target may answer and an unmapped access is answered here
	always_comb begin
		host_rsp_valid = busy;
		host_rsp       = RSP_ERR;
		if (own_dram) begin
			host_rsp_valid = busy && dram_rsp_valid;
			host_rsp       = dram_rsp;
		end else if (own_mmio) begin
			host_rsp_valid = busy && mmio_rsp_valid;
			host_rsp       = mmio_rsp;
		end
	end

	assign dram_rsp_ready = busy && own_dram && host_rsp_ready;
	assign mmio_rsp_ready = busy && own_mmio && host_rsp_ready;

	a_no_rsp_when_idle: assert property (@(posedge clk) disable iff (rst)
		dram_rsp_valid || mmio_rsp_valid |-> busy)
		else $error("Target response while the data-bus router is idle");

endmodule

//--- w3d_interconnect_host_mmio.sv
`timescale 1ns/1ns

module w3d_interconnect_host_mmio
	import w3d_bus_pkg::*;
	import w3d_map_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	input  logic     host_req_valid,
	output logic     host_req_ready,
	input  bus_req_t host_req,
	output logic     host_rsp_valid,
	input  logic     host_rsp_ready,
	output bus_rsp_t host_rsp,

	output logic     gfx_ctrl_req_valid,
	input  logic     gfx_ctrl_req_ready,
	output bus_req_t gfx_ctrl_req,
	input  logic     gfx_ctrl_rsp_valid,
	output logic     gfx_ctrl_rsp_ready,
	input  bus_rsp_t gfx_ctrl_rsp,

	output logic     external_io_req_valid,
	input  logic     external_io_req_ready,
	output bus_req_t external_io_req,
	input  logic     external_io_rsp_valid,
	output logic     external_io_rsp_ready,
	input  bus_rsp_t external_io_rsp
);

	map_addr_u addr;
	logic      reserved;
	logic      hit_gfx;
	logic      hit_ext;
	logic      accept;
	logic      busy;
	logic      own_gfx;
	logic      own_ext;
	bus_req_t  req_q;

	assign addr     = host_req.addr;
	assign reserved = addr.mmio.reg_addr > MMIO_REG_LAST;
	assign hit_gfx  = !reserved && addr.mmio.unit == UNIT_GFX_CTRL;
	assign hit_ext  = !reserved && addr.mmio.unit == UNIT_EXTERNAL_IO;

	assign host_req_ready = !busy;
	assign accept         = host_req_valid && host_req_ready;

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= host_req;
	end

	assign gfx_ctrl_req    = req_q;
	assign external_io_req = req_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy                  <= 1'b0;
			own_gfx               <= 1'b0;
			own_ext               <= 1'b0;
			gfx_ctrl_req_valid    <= 1'b0;
			external_io_req_valid <= 1'b0;
		end else if (accept) begin
			busy                  <= 1'b1;
			own_gfx               <= hit_gfx;
			own_ext               <= hit_ext;
			gfx_ctrl_req_valid    <= hit_gfx;
			external_io_req_valid <= hit_ext;
		end else begin
			if (gfx_ctrl_req_ready)
				gfx_ctrl_req_valid <= 1'b0;
			if (external_io_req_ready)
				external_io_req_valid <= 1'b0;
			if (host_rsp_valid && host_rsp_ready)
				busy <= 1'b0;
		end
	end

	always_comb begin
		host_rsp_valid = busy;  // A reserved register is answered with an error
		host_rsp       = RSP_ERR;
		if (own_gfx) begin
			host_rsp_valid = busy && gfx_ctrl_rsp_valid;
			host_rsp       = gfx_ctrl_rsp;
		end else if (own_ext) begin
			host_rsp_valid = busy && external_io_rsp_valid;
			host_rsp       = external_io_rsp;
		end
	end

	assign gfx_ctrl_rsp_ready    = busy && own_gfx && host_rsp_ready;
	assign external_io_rsp_ready = busy && own_ext && host_rsp_ready;

	// A stalled request keeps its valid and payload until the unit takes it
	property p_req_held(logic v, logic r, bus_req_t p);
		@(posedge clk) disable iff (rst) v && !r |=> v && $stable(p);
	endproperty

	a_gfx_req_held: assert property (p_req_held(gfx_ctrl_req_valid, gfx_ctrl_req_ready,
		gfx_ctrl_req))
		else $error("Graphics-control request changed under back-pressure");

	a_ext_req_held: assert property (p_req_held(external_io_req_valid, external_io_req_ready,
		external_io_req))
		else $error("External-I/O request changed under back-pressure");

endmodule

//--- w3d_interconnect_dram.sv
`timescale 1ns/1ns

module w3d_interconnect_dram
	import w3d_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	input  logic     host_dbus_req_valid,
	output logic     host_dbus_req_ready,
	input  bus_req_t host_dbus_req,
	output logic     host_dbus_rsp_valid,
	input  logic     host_dbus_rsp_ready,
	output bus_rsp_t host_dbus_rsp,

	input  logic     host_ibus_req_valid,
	output logic     host_ibus_req_ready,
	input  bus_req_t host_ibus_req,
	output logic     host_ibus_rsp_valid,
	input  logic     host_ibus_rsp_ready,
	output bus_rsp_t host_ibus_rsp,

	output logic     dram_req_valid,
	input  logic     dram_req_ready,
	output bus_req_t dram_req,
	input  logic     dram_rsp_valid,
	output logic     dram_rsp_ready,
	input  bus_rsp_t dram_rsp
);

	logic     busy;
	logic     last_ibus;  // Last grant, which is also the owner while busy
	logic     gnt_dbus;
	logic     gnt_ibus;
	bus_req_t req_q;

	// The master not granted last wins a tie and a lone requester always gets through
	assign host_dbus_req_ready = !busy && (last_ibus || !host_ibus_req_valid);
	assign host_ibus_req_ready = !busy && (!last_ibus || !host_dbus_req_valid);

	assign gnt_dbus = host_dbus_req_valid && host_dbus_req_ready;
	assign gnt_ibus = host_ibus_req_valid && host_ibus_req_ready;

	always_ff @(posedge clk) begin
		if (gnt_ibus)
			req_q <= host_ibus_req;
		else if (gnt_dbus)
			req_q <= host_dbus_req;
	end

	assign dram_req = req_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy           <= 1'b0;
			last_ibus      <= 1'b1;
			dram_req_valid <= 1'b0;
		end else if (gnt_dbus || gnt_ibus) begin
			busy           <= 1'b1;
			last_ibus      <= gnt_ibus;
			dram_req_valid <= 1'b1;
		end else begin
			if (dram_req_ready)
				dram_req_valid <= 1'b0;
			if (dram_rsp_valid && dram_rsp_ready)
				busy <= 1'b0;
		end
	end

	assign host_dbus_rsp_valid = busy && !last_ibus && dram_rsp_valid;
	assign host_ibus_rsp_valid = busy && last_ibus && dram_rsp_valid;
	assign host_dbus_rsp       = dram_rsp;
	assign host_ibus_rsp       = dram_rsp;

	assign dram_rsp_ready = busy && (last_ibus ? host_ibus_rsp_ready : host_dbus_rsp_ready);

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(gnt_dbus && gnt_ibus))
		else $error("DRAM granted to both buses in one cycle");

endmodule

//--- w3d_interconnect.sv
`timescale 1ns/1ns

module w3d_interconnect
	import w3d_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	input  logic     host_dbus_req_valid,
	output logic     host_dbus_req_ready,
	input  bus_req_t host_dbus_req,
	output logic     host_dbus_rsp_valid,
	input  logic     host_dbus_rsp_ready,
	output bus_rsp_t host_dbus_rsp,

	input  logic     host_ibus_req_valid,
	output logic     host_ibus_req_ready,
	input  bus_req_t host_ibus_req,
	output logic     host_ibus_rsp_valid,
	input  logic     host_ibus_rsp_ready,
	output bus_rsp_t host_ibus_rsp,

	output logic     dram_req_valid,
	input  logic     dram_req_ready,
	output bus_req_t dram_req,
	input  logic     dram_rsp_valid,
	output logic     dram_rsp_ready,
	input  bus_rsp_t dram_rsp,

	output logic     gfx_ctrl_req_valid,
	input  logic     gfx_ctrl_req_ready,
	output bus_req_t gfx_ctrl_req,
	input  logic     gfx_ctrl_rsp_valid,
	output logic     gfx_ctrl_rsp_ready,
	input  bus_rsp_t gfx_ctrl_rsp,

	output logic     external_io_req_valid,
	input  logic     external_io_req_ready,
	output bus_req_t external_io_req,
	input  logic     external_io_rsp_valid,
	output logic     external_io_rsp_ready,
	input  bus_rsp_t external_io_rsp
);

	// Data-bus DRAM traffic on its way to the arbiter
	logic     dbus_dram_req_valid;
	logic     dbus_dram_req_ready;
	bus_req_t dbus_dram_req;
	logic     dbus_dram_rsp_valid;
	logic     dbus_dram_rsp_ready;
	bus_rsp_t dbus_dram_rsp;

	logic     dbus_mmio_req_valid;
	logic     dbus_mmio_req_ready;
	bus_req_t dbus_mmio_req;
	logic     dbus_mmio_rsp_valid;
	logic     dbus_mmio_rsp_ready;
	bus_rsp_t dbus_mmio_rsp;

	w3d_interconnect_host_data data
	(
		.clk,
		.rst,
		.host_req_valid(host_dbus_req_valid),
		.host_req_ready(host_dbus_req_ready),
		.host_req(host_dbus_req),
		.host_rsp_valid(host_dbus_rsp_valid),
		.host_rsp_ready(host_dbus_rsp_ready),
		.host_rsp(host_dbus_rsp),
		.dram_req_valid(dbus_dram_req_valid),
		.dram_req_ready(dbus_dram_req_ready),
		.dram_req(dbus_dram_req),
		.dram_rsp_valid(dbus_dram_rsp_valid),
		.dram_rsp_ready(dbus_dram_rsp_ready),
		.dram_rsp(dbus_dram_rsp),
		.mmio_req_valid(dbus_mmio_req_valid),
		.mmio_req_ready(dbus_mmio_req_ready),
		.mmio_req(dbus_mmio_req),
		.mmio_rsp_valid(dbus_mmio_rsp_valid),
		.mmio_rsp_ready(dbus_mmio_rsp_ready),
		.mmio_rsp(dbus_mmio_rsp)
	);

	w3d_interconnect_host_mmio mmio
	(
		.*,
		.host_req_valid(dbus_mmio_req_valid),
		.host_req_ready(dbus_mmio_req_ready),
		.host_req(dbus_mmio_req),
		.host_rsp_valid(dbus_mmio_rsp_valid),
		.host_rsp_ready(dbus_mmio_rsp_ready),
		.host_rsp(dbus_mmio_rsp)
	);

	// Instruction bus and DRAM ports connect by name
	w3d_interconnect_dram mem
	(
		.*,
		.host_dbus_req_valid(dbus_dram_req_valid),
		.host_dbus_req_ready(dbus_dram_req_ready),
		.host_dbus_req(dbus_dram_req),
		.host_dbus_rsp_valid(dbus_dram_rsp_valid),
		.host_dbus_rsp_ready(dbus_dram_rsp_ready),
		.host_dbus_rsp(dbus_dram_rsp)
	);

endmodule

//--- w3d_interconnect_tb_targets.sv
`timescale 1ns/1ns

module w3d_interconnect_tb_targets
	import w3d_bus_pkg::*;
#(
	parameter logic [31:0] SEED   = 32'd1,
	parameter bit          SPARSE = 1'b1  // Set for a sparse DRAM store and clear for 16 registers
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	output logic     req_ready,
	input  bus_req_t req,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	output bus_rsp_t rsp
);

	logic [DATA_W-1:0] words [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0] regs [16];
	logic [31:0]       rnd = SEED;
	int                served = 0;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Unwritten DRAM words read back as a pattern of their own address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input bus_req_t r);
		logic [31:0] w;
		w = old;
		for (int b = 0; b < STRB_W; b++)
			if (r.wstrb[b])
				w[8*b +: 8] = r.wdata[8*b +: 8];
		return w;
	endfunction

	initial begin
		bus_req_t    cur;
		logic [31:0] old;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp       = '0;
		foreach (regs[i])
			regs[i] = '0;
		forever begin
			@(posedge clk);
			if (!rst && req_valid && req_ready) begin
				cur = req;
				served++;
				if (SPARSE)
					old = words.exists(cur.addr) ? words[cur.addr] : fill_word(cur.addr);
				else
					old = regs[cur.addr[5:2]];
				#1 req_ready = 1'b0;
				rnd = next_random(rnd);
				repeat (rnd[1:0]) begin  // Latency of 0 to 3 cycles
					@(posedge clk);
					#1;
				end
				if (cur.write && SPARSE)
					words[cur.addr] = merge(old, cur);
				else if (cur.write)
					regs[cur.addr[5:2]] = merge(old, cur);
				rsp       = '{rdata: cur.write ? '0 : old, err: 1'b0};
				rsp_valid = 1'b1;
				@(posedge clk);
				while (!rsp_ready)
					@(posedge clk);
				#1 rsp_valid = 1'b0;
			end else begin
				#1;
			end
			rnd       = next_random(rnd);
			req_ready = !rst && rnd[3:2] != 2'b00;  // Stalls about a quarter of the cycles
		end
	end

endmodule

//--- w3d_interconnect_tb.sv
`timescale 1ns/1ns

module w3d_interconnect_tb
	import w3d_bus_pkg::*;
	import w3d_map_pkg::*;
();

	localparam int N_DBUS      = 250;
	localparam int N_IBUS      = 150;
	localparam int CLK_NS      = 8;
	localparam int WATCHDOG_NS = (N_DBUS + N_IBUS) * 40 * CLK_NS;

	logic     clk = 1'b0;
	logic     rst = 1'b1;
	logic     host_dbus_req_valid, host_dbus_req_ready, host_dbus_rsp_valid, host_dbus_rsp_ready;
	bus_req_t host_dbus_req;
	bus_rsp_t host_dbus_rsp;
	logic     host_ibus_req_valid, host_ibus_req_ready, host_ibus_rsp_valid, host_ibus_rsp_ready;
	bus_req_t host_ibus_req;
	bus_rsp_t host_ibus_rsp;
	logic     dram_req_valid, dram_req_ready, dram_rsp_valid, dram_rsp_ready;
	bus_req_t dram_req;
	bus_rsp_t dram_rsp;
	logic     gfx_ctrl_req_valid, gfx_ctrl_req_ready, gfx_ctrl_rsp_valid, gfx_ctrl_rsp_ready;
	bus_req_t gfx_ctrl_req;
	bus_rsp_t gfx_ctrl_rsp;
	logic     external_io_req_valid, external_io_req_ready;
	logic     external_io_rsp_valid, external_io_rsp_ready;
	bus_req_t external_io_req;
	bus_rsp_t external_io_rsp;

	logic [31:0] dram_model [logic [31:0]];
	logic [31:0] gfx_model [16];
	logic [31:0] ext_model [16];
	int          errors = 0;
	int          issued = 0;
	int          completed = 0;
	int          dram_n = 0;
	int          gfx_n = 0;
	int          ext_n = 0;
	int          grants_d = 0;
	int          grants_i = 0;
	int          rsp_d = 0;
	int          rsp_i = 0;
	logic        last_gnt_ibus = 1'b1;  // Arbiter leaves reset pointing at the instruction bus
	logic        dbus_wait = 1'b0;
	logic        dbus_wait_dram = 1'b0;
	logic        ibus_wait = 1'b0;
	logic        held_d = 1'b0;
	logic        held_i = 1'b0;
	bus_rsp_t    last_d;
	bus_rsp_t    last_i;

	w3d_interconnect DUT (.*);

	w3d_interconnect_tb_targets #(.SEED(32'd23655 ^ 32'h0000_0101), .SPARSE(1'b1)) dram_target (
		.clk, .rst, .req_valid(dram_req_valid), .req_ready(dram_req_ready), .req(dram_req),
		.rsp_valid(dram_rsp_valid), .rsp_ready(dram_rsp_ready), .rsp(dram_rsp));
	w3d_interconnect_tb_targets #(.SEED(32'd23655 ^ 32'h0000_0202), .SPARSE(1'b0)) gfx_target (
		.clk, .rst, .req_valid(gfx_ctrl_req_valid), .req_ready(gfx_ctrl_req_ready),
		.req(gfx_ctrl_req), .rsp_valid(gfx_ctrl_rsp_valid), .rsp_ready(gfx_ctrl_rsp_ready),
		.rsp(gfx_ctrl_rsp));
	w3d_interconnect_tb_targets #(.SEED(32'd23655 ^ 32'h0000_0303), .SPARSE(1'b0)) ext_target (
		.clk, .rst, .req_valid(external_io_req_valid), .req_ready(external_io_req_ready),
		.req(external_io_req), .rsp_valid(external_io_rsp_valid),
		.rsp_ready(external_io_rsp_ready), .rsp(external_io_rsp));

	always #(CLK_NS / 2) clk = !clk;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] dram_read(input logic [31:0] a);
		return dram_model.exists(a) ? dram_model[a] : ({a[15:0], a[31:16]} ^ 32'h5a3c_96e1);
	endfunction

	// Upper half of the DRAM window starts at 0x1000_0000
	function automatic logic [31:0] dram_addr(input logic upper, input logic [5:0] idx);
		map_addr_u a;
		a.dram.region = REGION_DRAM;
		a.dram.offset = {upper, 20'd0, idx, 2'b00};
		return a;
	endfunction

	function automatic logic [31:0] mmio_addr(input logic unit, input logic [27:0] reg_addr);
		map_addr_u a;
		a.mmio.region   = REGION_MMIO;
		a.mmio.unit     = unit;
		a.mmio.reg_addr = reg_addr;
		return a;
	endfunction

	task automatic check_rsp(input string bus, input bus_rsp_t got, input bus_rsp_t exp,
		input logic [31:0] addr);
		assert (got == exp) else begin
			errors++;
			$display("mismatch at %0t: %s addr %h got rdata %h err %b, expected rdata %h err %b",
				$time, bus, addr, got.rdata, got.err, exp.rdata, exp.err);
		end
	endtask

	task automatic run_dbus();
		logic [31:0] rnd;
		logic [3:0]  idx;
		bus_req_t    r;
		bus_rsp_t    exp;
		rnd = 32'd23655;
		for (int n = 0; n < N_DBUS; n++) begin
			rnd = next_random(rnd);
			idx = rnd[11:8];
			r   = '{addr: '0, write: 1'b0, wdata: {rnd[15:0], rnd[31:16]}, wstrb: 4'hf};
			exp = '{rdata: '0, err: 1'b0};
			case (rnd[2:0])
				3'd0, 3'd1: begin
					r.addr    = dram_addr(1'b0, rnd[13:8]);
					exp.rdata = dram_read(r.addr);
					dram_n++;
				end
				3'd2, 3'd3: begin  // Data-bus writes stay in the upper half
					r.addr  = dram_addr(1'b1, rnd[13:8]);
					r.write = rnd[0];
					if (r.write)
						dram_model[r.addr] = r.wdata;
					else
						exp.rdata = dram_read(r.addr);
					dram_n++;
				end
				3'd4, 3'd5: begin
					r.addr  = mmio_addr(rnd[0] ? UNIT_EXTERNAL_IO : UNIT_GFX_CTRL,
						{22'd0, idx, 2'b00});
					r.write = rnd[16];
					if (rnd[0] && r.write)
						ext_model[idx] = r.wdata;
					else if (r.write)
						gfx_model[idx] = r.wdata;
					else
						exp.rdata = rnd[0] ? ext_model[idx] : gfx_model[idx];
					if (rnd[0])
						ext_n++;
					else
						gfx_n++;
				end
				3'd6: begin
					r.addr  = {3'd2 + 3'(rnd[13:8] % 6'd6), rnd[28:0]};  // 0x4000_0000 and up
					r.write = rnd[16];
					exp     = '{rdata: '0, err: 1'b1};
				end
				default: begin
					r.addr  = mmio_addr(rnd[3], {rnd[27:24] | 4'h1, rnd[23:0]});
					r.write = rnd[16];
					exp     = '{rdata: '0, err: 1'b1};
				end
			endcase
			host_dbus_req       = r;
			host_dbus_req_valid = 1'b1;
			@(posedge clk);
			while (!host_dbus_req_ready)
				@(posedge clk);
			issued++;
			#1 host_dbus_req_valid = 1'b0;
			dbus_wait      = 1'b1;
			dbus_wait_dram = rnd[2:0] < 3'd4;
			rnd = next_random(rnd);
			host_dbus_rsp_ready = rnd[4] | rnd[5];
			@(posedge clk);
			while (!(host_dbus_rsp_valid && host_dbus_rsp_ready)) begin
				#1;
				rnd = next_random(rnd);
				host_dbus_rsp_ready = rnd[4] | rnd[5];
				@(posedge clk);
			end
			check_rsp("data bus", host_dbus_rsp, exp, r.addr);
			#1 dbus_wait = 1'b0;
		end
	endtask

	task automatic run_ibus();
		logic [31:0] rnd;
		logic [31:0] addr;
		bus_rsp_t    exp;
		rnd = 32'd23655 ^ 32'h0000_5a5a;
		for (int n = 0; n < N_IBUS; n++) begin
			rnd  = next_random(rnd);
			addr = dram_addr(1'b0, rnd[13:8]);  // Fetches only touch the lower half
			exp  = '{rdata: dram_read(addr), err: 1'b0};
			host_ibus_req       = '{addr: addr, write: 1'b0, wdata: '0, wstrb: 4'h0};
			host_ibus_req_valid = 1'b1;
			@(posedge clk);
			while (!host_ibus_req_ready)
				@(posedge clk);
			issued++;
			#1 host_ibus_req_valid = 1'b0;
			ibus_wait = 1'b1;
			rnd = next_random(rnd);
			host_ibus_rsp_ready = rnd[4] | rnd[5];
			@(posedge clk);
			while (!(host_ibus_rsp_valid && host_ibus_rsp_ready)) begin
				#1;
				rnd = next_random(rnd);
				host_ibus_rsp_ready = rnd[4] | rnd[5];
				@(posedge clk);
			end
			check_rsp("instruction bus", host_ibus_rsp, exp, addr);
			#1 ibus_wait = 1'b0;
		end
	endtask

	// Arbitration order, response routing and response stability
	always @(posedge clk) begin
		logic gnt_d;
		logic gnt_i;
		gnt_d = DUT.dbus_dram_req_valid && DUT.dbus_dram_req_ready;
		gnt_i = host_ibus_req_valid && host_ibus_req_ready;
		if (!rst && (gnt_d || gnt_i)) begin
			if (DUT.dbus_dram_req_valid && host_ibus_req_valid)
				assert (gnt_i != last_gnt_ibus) else begin
					errors++;
					$display("mismatch at %0t: DRAM granted to the same bus twice in a row",
						$time);
				end
			last_gnt_ibus = gnt_i;
			grants_d += int'(gnt_d);
			grants_i += int'(gnt_i);
		end
		if (dram_rsp_valid && dram_rsp_ready) begin
			if (host_ibus_rsp_valid)
				rsp_i++;
			else if (host_dbus_rsp_valid)
				rsp_d++;
			assert (host_ibus_rsp_valid != (host_dbus_rsp_valid && dbus_wait_dram)) else begin
				errors++;
				$display("DRAM response at %0t did not reach exactly one host", $time);
			end
		end
		assert ((!host_dbus_rsp_valid || dbus_wait) && (!host_ibus_rsp_valid || ibus_wait))
		else begin
			errors++;
			$display("Response at %0t on a host bus with no request outstanding", $time);
		end
		if (held_d)
			assert (host_dbus_rsp_valid && host_dbus_rsp == last_d) else begin
				errors++;
				$display("mismatch at %0t: data-bus response changed before it was taken",
					$time);
			end
		if (held_i)
			assert (host_ibus_rsp_valid && host_ibus_rsp == last_i) else begin
				errors++;
				$display("mismatch at %0t: instruction response changed before it was taken",
					$time);
			end
		if (host_dbus_rsp_valid && host_dbus_rsp_ready)
			completed++;
		if (host_ibus_rsp_valid && host_ibus_rsp_ready)
			completed++;
		held_d = host_dbus_rsp_valid && !host_dbus_rsp_ready;
		held_i = host_ibus_rsp_valid && !host_ibus_rsp_ready;
		last_d = host_dbus_rsp;
		last_i = host_ibus_rsp;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired with %0d of %0d transactions completed", completed,
			N_DBUS + N_IBUS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		host_dbus_req_valid = 1'b0;
		host_dbus_req       = '0;
		host_dbus_rsp_ready = 1'b0;
		host_ibus_req_valid = 1'b0;
		host_ibus_req       = '0;
		host_ibus_rsp_ready = 1'b0;
		foreach (gfx_model[i]) begin
			gfx_model[i] = '0;
			ext_model[i] = '0;
		end
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		@(posedge clk);
		#1;
		fork
			run_dbus();
			run_ibus();
		join
		repeat (4) @(posedge clk);
		assert (completed == issued) else begin
			errors++;
			$display("Host buses returned %0d responses for %0d issued transactions",
				completed, issued);
		end
		assert (grants_d == rsp_d && grants_i == rsp_i) else begin
			errors++;
			$display("DRAM grants %0d/%0d do not match response owners %0d/%0d",
				grants_d, grants_i, rsp_d, rsp_i);
		end
		assert (dram_target.served == dram_n + N_IBUS && gfx_target.served == gfx_n
			&& ext_target.served == ext_n) else begin
			errors++;
			$display("A target served a different number of requests than were sent to it");
		end
		$display("Errors: %0d, issued: %0d, completed: %0d, DRAM grants dbus %0d ibus %0d",
			errors, issued, completed, grants_d, grants_i);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- w3d_interconnect.f
w3d_bus_pkg.sv
w3d_map_pkg.sv
w3d_interconnect_host_data.sv
w3d_interconnect_host_mmio.sv
w3d_interconnect_dram.sv
w3d_interconnect.sv
w3d_interconnect_tb_targets.sv
w3d_interconnect_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= w3d_interconnect_tb
FILELIST  ?= w3d_interconnect.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Simulation failed" $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
